/* testbench/id_testdata.txt */
# test flush valid read_en inst0 inst1 unk0 unk1 first_jmp exc pc pc_next, then expected
# set_pc redirect full dontcare v0 v1 uop0 imm0 rd0 exc0 pc0 pcn0 uop1 exc1 pc1 pcn1 (hex)
1 0 1 0 00100C41 001118A4 0 0 0 0 1000 1008 0 0 0 0 1 1 42 0 1 0 1000 1004 46 0 1004 1008
2 0 1 3 02BFFD07 142468A9 0 0 0 0 1008 1010 0 0 0 0 1 1 43 FFFFFFFF 7 0 1008 100C 4B 0 100C 1010
3 0 1 3 2880216A 298011AC 0 0 0 0 1010 1018 0 0 0 0 1 1 8F 8 A 0 1010 1014 91 0 1014 1018
4 0 1 3 54000800 4C0000A1 0 0 0 0 1018 1020 0 0 0 0 1 1 E3 8 1 0 1018 101C E7 0 101C 1020
5 0 1 3 002B0000 002A0000 0 0 0 0 1020 1028 0 0 0 0 1 1 0 0 0 B 1020 1024 0 C 1024 1028
6 0 1 3 FFFFFFFF 00100C41 0 0 0 8 1028 1030 0 0 0 0 1 1 0 0 1F 8 1028 102C 42 8 102C 1030
7 0 1 3 FFFFFFFF 03400000 0 0 0 0 1030 1038 0 0 0 0 1 0 0 0 1F D 1030 1034 0 0 0 0
8 0 1 1 00100C41 001118A4 0 0 0 0 2004 2010 0 0 0 0 1 0 46 0 4 0 2008 2010 0 0 0 0
9 0 1 1 2880216A 298011AC 0 0 1 0 3000 4000 0 0 0 0 1 0 8F 8 A 0 3000 4000 0 0 0 0
10 0 1 1 03400000 03400000 0 0 0 0 3008 3010 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
11 0 1 0 5BFFF822 00100C41 1 0 0 0 5000 5008 1 4FF8 0 0 1 0 D5 FFFFFFF8 2 0 5000 4FF8 0 0 0 0
12 0 1 1 00100C41 50001000 1 1 0 0 6000 6008 1 6014 0 0 1 1 42 0 1 0 6000 6004 DD 0 6004 6014
13 0 1 3 00100C41 001118A4 0 0 0 0 7000 7008 0 0 0 0 1 1 42 0 1 0 7000 7004 46 0 7004 7008
14 0 1 0 00100C41 001118A4 0 0 0 0 7008 7010 0 0 0 0 1 1 42 0 1 0 7000 7004 46 0 7004 7008
15 0 1 0 00100C41 001118A4 0 0 0 0 7010 7018 0 0 0 1 1 1 42 0 1 0 7000 7004 46 0 7004 7008
16 0 1 0 00100C41 001118A4 0 0 0 0 7018 7020 0 0 0 1 1 1 42 0 1 0 7000 7004 46 0 7004 7008
17 0 1 0 00100C41 001118A4 0 0 0 0 7020 7028 0 0 1 0 1 1 42 0 1 0 7000 7004 46 0 7004 7008
18 0 0 3 0 0 0 0 0 0 0 0 0 0 0 0 1 1 42 0 1 0 7008 700C 46 0 700C 7010
19 0 0 3 0 0 0 0 0 0 0 0 0 0 0 0 1 1 42 0 1 0 7010 7014 46 0 7014 7018
20 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
21 0 1 0 00100C41 001118A4 0 0 0 0 8000 8008 0 0 0 0 1 1 42 0 1 0 8000 8004 46 0 8004 8008

/* build.f */
source/id_pkg.sv
source/pre_decoder.sv
source/fetch_buffer.sv
source/inst_decoder.sv
source/id_stage.sv
testbench/id_stage_chk.sv
testbench/id_stage_tb.sv

/* testbench/id_stage_tb.sv */
// ##########################################################
// replays testbench/id_testdata.txt, one record per fetch group
// outputs are compared one edge after the record is driven
// ##########################################################
`timescale 1ns/1ps

module id_stage_tb
    import id_pkg::*;
();

    logic        clk, rst_n, flush, input_valid;
    logic [1:0]  read_en;
    inst_t       inst0, inst1;
    logic        unknown0, unknown1, first_inst_jmp;
    exc_t        exc_in;
    addr_t       pc_in, pc_next_in;
    logic        full, out_valid0, out_valid1;
    uop_t        uop0, uop1;
    logic [31:0] imm0, imm1;
    reg_idx_t    rd0, rd1, rj0, rj1, rk0, rk1;
    exc_t        exc0, exc1;
    addr_t       pc0, pc1, pc_next0, pc_next1;
    logic        feedback_valid, set_pc;
    addr_t       pc_for_predict, jmpdist0, jmpdist1, redirect_pc;
    br_cat_t     category0, category1;

    logic [31:0] f [0:27]; // fields of the current record
    inst_t       sent [addr_t]; // words fetched, by pc
    int          errors = 0;
    int          tests = 0;
    int          bad_tests = 0;
    int          tnum;
    logic        test_bad;

    id_stage i_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            test_bad = 1'b1;
            $display("FAIL @%0t: test %0d %s is %h, expected %h", $time, tnum, what, got, exp);
        end
    endtask

    // branch class by opcode, as the predictor sees it
    function automatic br_cat_t branch_class(input inst_t i);
        case (i[31:26])
            OPC6_BEQ, OPC6_BNE: return CAT_COND;
            OPC6_B, OPC6_BL:    return CAT_DIRECT;
            OPC6_JIRL:          return CAT_INDIRECT;
            default:            return CAT_NONE;
        endcase
    endfunction

    // byte offset of a branch, zero for anything else
    function automatic addr_t branch_offset(input inst_t i);
        logic signed [31:0] words;
        case (i[31:26])
            OPC6_BEQ, OPC6_BNE, OPC6_JIRL: words = $signed(i[25:10]);
            OPC6_B, OPC6_BL:               words = $signed({i[9:0], i[25:10]}); // high part first
            default:                       words = '0;
        endcase
        return words <<< 2;
    endfunction

    function automatic logic [31:0] imm_of(input inst_t i);
        logic signed [31:0] si12;
        si12 = $signed(i[21:10]);
        if ((i[31:22] == OPC10_ADDI_W) || (i[31:22] == OPC10_LD_W)
                || (i[31:22] == OPC10_ST_W)) begin
            return si12;
        end
        if (i[31:25] == OPC7_LU12I_W) begin
            return {i[24:5], 12'h000}; // upper 20 bits
        end
        return branch_offset(i);
    endfunction

    // bl always links through r1
    function automatic reg_idx_t rd_of(input inst_t i);
        return (i[31:26] == OPC6_BL) ? 5'd1 : i[4:0];
    endfunction

    // predictor feedback follows the fetch group directly
    task automatic check_predict();
        compare("feedback_valid", feedback_valid, f[2][0]);
        compare("pc_for_predict", pc_for_predict, f[10]);
        compare("category0", category0, branch_class(f[4]));
        compare("category1", category1, branch_class(f[5]));
        compare("jmpdist0", jmpdist0, f[10] + branch_offset(f[4]));
        compare("jmpdist1", jmpdist1, f[10] + 32'd4 + branch_offset(f[5]));
    endtask

    // fields taken from the word fetched at exp_pc
    task automatic check_fields(input string slot, input addr_t exp_pc, input logic [31:0] imm,
                                input reg_idx_t rd, input reg_idx_t rj, input reg_idx_t rk);
        inst_t i;
        if (!sent.exists(exp_pc)) begin
            errors++;
            test_bad = 1'b1;
            $display("test %0d expects pc %h, which was never fetched", tnum, exp_pc);
        end else begin
            i = sent[exp_pc];
            compare({"imm", slot}, imm, imm_of(i));
            compare({"rd", slot}, rd, rd_of(i));
            compare({"rj", slot}, rj, i[9:5]);
            compare({"rk", slot}, rk, i[14:10]);
        end
    endtask

    task automatic drive_idle();
        flush          = 1'b0;
        input_valid    = 1'b0;
        read_en        = 2'b00;
        inst0          = '0;
        inst1          = '0;
        unknown0       = 1'b0;
        unknown1       = 1'b0;
        first_inst_jmp = 1'b0;
        exc_in         = '0;
        pc_in          = '0;
        pc_next_in     = '0;
    endtask

    initial begin
        int    fd;
        int    n;
        int    cycles;
        logic  aborted;
        string line;

        void'($urandom(17));
        aborted = 1'b0;
        drive_idle();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        fd = $fopen("testbench/id_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/id_testdata.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue; // blank or column notes
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                f[20], f[21], f[22], f[23], f[24], f[25], f[26], f[27]);
            if (n != 28) continue;
            tnum     = f[0];
            test_bad = 1'b0;
            @(posedge clk);
            #1;
            flush          = f[1][0];
            input_valid    = f[2][0];
            read_en        = f[3][1:0];
            inst0          = f[4];
            inst1          = f[5];
            unknown0       = f[6][0];
            unknown1       = f[7][0];
            first_inst_jmp = f[8][0];
            exc_in         = f[9][6:0];
            pc_in          = f[10];
            pc_next_in     = f[11];
            if (f[2][0]) begin
                sent[f[10]]         = f[4];
                sent[f[10] + 32'd4] = f[5]; // slot 1 sits at pc+4
            end
            #3; // redirect is combinational
            compare("set_pc", set_pc, f[12]);
            if (f[12][0]) compare("redirect_pc", redirect_pc, f[13]);
            check_predict();
            @(posedge clk);
            #1 drive_idle();
            cycles = 0;
            while (f[16][0] && !out_valid0 && cycles < 20) begin
                @(posedge clk);
                #1 cycles++;
            end
            if (f[16][0] && !out_valid0) begin
                $display("timeout in test %0d, out_valid0 never rose", tnum);
                aborted = 1'b1;
            end else begin
                compare("full", full, f[14]);
                if (!f[15][0]) begin // don't-care records skip this
                    compare("out_valid0", out_valid0, f[16]);
                    compare("out_valid1", out_valid1, f[17]);
                    if (f[16][0]) begin
                        compare("uop0", uop0, f[18]);
                        compare("imm0", imm0, f[19]);
                        compare("rd0", rd0, f[20]);
                        compare("exc0", exc0, f[21]);
                        compare("pc0", pc0, f[22]);
                        compare("pc_next0", pc_next0, f[23]);
                        check_fields("0", f[22], imm0, rd0, rj0, rk0);
                    end
                    if (f[17][0]) begin
                        compare("uop1", uop1, f[24]);
                        compare("exc1", exc1, f[25]);
                        compare("pc1", pc1, f[26]);
                        compare("pc_next1", pc_next1, f[27]);
                        check_fields("1", f[26], imm1, rd1, rj1, rk1);
                    end
                end
                tests++;
                if (test_bad) bad_tests++;
                $display("test %0d %s", tnum, test_bad ? "failed" : "ok");
                repeat ($urandom % 3) @(posedge clk); // idle gap, state holds
            end
        end
        if (fd != 0) $fclose(fd);

        errors = errors + i_id_stage.i_chk.fail_count;
        $display("tests %0d, failed tests %0d, failed checks %0d", tests, bad_tests, errors);
        if (!aborted && errors == 0 && tests > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* testbench/id_stage_chk.sv */
// ##########################################################
// invariants of the decode stage, bound into id_stage
// ##########################################################
`timescale 1ns/1ps

module id_stage_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        flush,
    input logic [1:0]  read_en,
    input logic        full,
    input logic        out_valid0,
    input logic [31:0] pc0
);

    int fail_count = 0; // failed assertions so far

    // backend only pops none, one or two in order
    a_read_en_legal: assert property (@(posedge clk) disable iff (!rst_n)
        read_en != 2'b10)
        else begin
            fail_count++;
            $error("read_en 10 is not a legal pop request");
        end

    // a stalled head keeps its entry until popped
    a_head_holds: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid0 && (read_en == 2'b00) && !flush |=> out_valid0 && $stable(pc0))
        else begin
            fail_count++;
            $error("head entry changed while read_en was 00");
        end

    a_full_low_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !full)
        else begin
            fail_count++;
            $error("full is high right after reset");
        end

endmodule

bind id_stage id_stage_chk i_chk (.*);

/* source/id_stage.sv */
// ##########################################################
// decode stage top, fetch must stop while full is high
// pc_in with bit 2 set means only inst1 is meaningful
// ##########################################################
`timescale 1ns/1ps

module id_stage
    import id_pkg::*;
#(
    parameter int FB_DEPTH = 8,
    parameter int FB_SLACK = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        input_valid,
    input  logic [1:0]  read_en,
    input  inst_t       inst0,
    input  inst_t       inst1,
    input  logic        unknown0,       // predictor has no entry for slot 0
    input  logic        unknown1,
    input  logic        first_inst_jmp, // slot 1 is past a taken branch
    input  exc_t        exc_in,
    input  addr_t       pc_in,
    input  addr_t       pc_next_in,
    output logic        full,
    output logic        out_valid0,
    output logic        out_valid1,
    output uop_t        uop0,
    output uop_t        uop1,
    output logic [31:0] imm0,
    output logic [31:0] imm1,
    output reg_idx_t    rd0,
    output reg_idx_t    rd1,
    output reg_idx_t    rj0,
    output reg_idx_t    rj1,
    output reg_idx_t    rk0,
    output reg_idx_t    rk1,
    output exc_t        exc0,
    output exc_t        exc1,
    output addr_t       pc0,
    output addr_t       pc1,
    output addr_t       pc_next0,
    output addr_t       pc_next1,
    output logic        feedback_valid,
    output addr_t       pc_for_predict,
    output addr_t       jmpdist0,
    output addr_t       jmpdist1,
    output br_cat_t     category0,
    output br_cat_t     category1,
    output addr_t       redirect_pc,
    output logic        set_pc
);

    addr_t     offset0, offset1;
    addr_t     pc_slot1;
    addr_t     pc_next_sel;
    addr_t     pc_next_slot0;
    logic      slot_ok0, slot_ok1;   // before redirect filtering
    logic      should_jmp0, should_jmp1;
    logic      redir0, redir1;
    logic      valid0, valid1;
    logic      seq1;                 // slot 1 follows slot 0 in order
    fb_entry_t entry0, entry1;
    fb_entry_t push_entry0, push_entry1;
    logic [1:0] push_count;
    fb_entry_t head_entry0, head_entry1;
    logic      head_valid0, head_valid1;

    pre_decoder u_pre0 (.inst(inst0), .category(category0), .offset(offset0));
    pre_decoder u_pre1 (.inst(inst1), .category(category1), .offset(offset1));

    assign pc_slot1       = pc_in + 32'd4;
    assign jmpdist0       = pc_in + offset0;
    assign jmpdist1       = pc_slot1 + offset1;
    assign pc_for_predict = pc_in;
    assign feedback_valid = input_valid;

    // nops are dropped unless they carry a fetch fault
    assign slot_ok0 = input_valid && !pc_in[2] && ((inst0 != INST_NOP) || (exc_in != EXC_NONE));
    assign slot_ok1 = input_valid && !first_inst_jmp
                   && ((inst1 != INST_NOP) || (exc_in != EXC_NONE));

    // static guess, backward conditional is taken
    assign should_jmp0 = (category0 == CAT_DIRECT) || ((category0 == CAT_COND) && offset0[31]);
    assign should_jmp1 = (category1 == CAT_DIRECT) || ((category1 == CAT_COND) && offset1[31]);

    assign redir0      = slot_ok0 && unknown0 && should_jmp0; // oldest slot wins
    assign redir1      = slot_ok1 && !redir0 && unknown1 && should_jmp1;
    assign set_pc      = redir0 | redir1;
    assign redirect_pc = redir0 ? jmpdist0 : jmpdist1;

    assign valid0 = slot_ok0;
    assign valid1 = slot_ok1 && !redir0; // squashed behind a redirect

    assign pc_next_sel   = set_pc ? redirect_pc : pc_next_in;
    assign seq1          = !first_inst_jmp && !redir0;
    assign pc_next_slot0 = seq1 ? pc_slot1 : pc_next_sel;

    assign entry0 = '{exc: exc_in, pc_next: pc_next_slot0, pc: pc_in, inst: inst0};
    assign entry1 = '{exc: exc_in, pc_next: pc_next_sel, pc: pc_slot1, inst: inst1};

    // compact so the oldest valid entry leads
    assign push_entry0 = valid0 ? entry0 : entry1;
    assign push_entry1 = entry1;
    assign push_count  = {1'b0, valid0} + {1'b0, valid1};

    fetch_buffer #(
        .FB_DEPTH (FB_DEPTH),
        .FB_SLACK (FB_SLACK)
    ) u_fetch_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .push_entry0 (push_entry0),
        .push_entry1 (push_entry1),
        .push_count  (push_count),
        .read_en     (read_en),
        .head_entry0 (head_entry0),
        .head_entry1 (head_entry1),
        .head_valid0 (head_valid0),
        .head_valid1 (head_valid1),
        .full        (full)
    );

    inst_decoder u_dec0 (
        .entry (head_entry0), .entry_valid (head_valid0),
        .uop   (uop0), .imm (imm0), .rd (rd0), .rj (rj0), .rk (rk0),
        .pc    (pc0), .pc_next (pc_next0), .exc (exc0), .valid (out_valid0)
    );

    inst_decoder u_dec1 (
        .entry (head_entry1), .entry_valid (head_valid1),
        .uop   (uop1), .imm (imm1), .rd (rd1), .rj (rj1), .rk (rk1),
        .pc    (pc1), .pc_next (pc_next1), .exc (exc1), .valid (out_valid1)
    );

endmodule

/* source/inst_decoder.sv */
// ##########################################################
// decodes one queued entry into a uop, subset only
// anything outside the subset raises EXC_INE
// ##########################################################
`timescale 1ns/1ps

module inst_decoder
    import id_pkg::*;
(
    input  fb_entry_t   entry,
    input  logic        entry_valid,
    output uop_t        uop,
    output logic [31:0] imm,
    output reg_idx_t    rd,
    output reg_idx_t    rj,
    output reg_idx_t    rk,
    output addr_t       pc,
    output addr_t       pc_next,
    output exc_t        exc,
    output logic        valid
);

    inst_t       inst;
    logic [31:0] si12;   // addi.w, ld.w, st.w
    logic [31:0] ui20;   // lu12i.w
    logic [31:0] offs16; // beq, bne, jirl
    logic [31:0] offs26; // b, bl
    uop_t        dec_uop;
    logic [31:0] dec_imm;
    reg_idx_t    dec_rd;
    exc_t        dec_exc;

    assign inst   = entry.inst;
    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign ui20   = {inst[24:5], 12'h000};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        dec_uop = '0;
        dec_imm = '0;
        dec_rd  = inst[4:0];
        dec_exc = EXC_NONE;
        if (inst[31:15] == OPC17_ADD_W) begin
            dec_uop = '{unit: UNIT_ALU, op: OP_ADD, wr_rd: 1'b1, use_imm: 1'b0};
        end else if (inst[31:15] == OPC17_SUB_W) begin
            dec_uop = '{unit: UNIT_ALU, op: OP_SUB, wr_rd: 1'b1, use_imm: 1'b0};
        end else if (inst[31:22] == OPC10_ADDI_W) begin
            dec_uop = '{unit: UNIT_ALU, op: OP_ADD, wr_rd: 1'b1, use_imm: 1'b1};
            dec_imm = si12;
        end else if (inst[31:25] == OPC7_LU12I_W) begin
            dec_uop = '{unit: UNIT_ALU, op: OP_LUI, wr_rd: 1'b1, use_imm: 1'b1};
            dec_imm = ui20;
        end else if (inst[31:22] == OPC10_LD_W) begin
            dec_uop = '{unit: UNIT_LSU, op: OP_LD, wr_rd: 1'b1, use_imm: 1'b1};
            dec_imm = si12;
        end else if (inst[31:22] == OPC10_ST_W) begin
            // rd is the store data source here
            dec_uop = '{unit: UNIT_LSU, op: OP_ST, wr_rd: 1'b0, use_imm: 1'b1};
            dec_imm = si12;
        end else if (inst[31:26] == OPC6_BEQ) begin
            dec_uop = '{unit: UNIT_BRU, op: OP_BEQ, wr_rd: 1'b0, use_imm: 1'b1};
            dec_imm = offs16;
        end else if (inst[31:26] == OPC6_BNE) begin
            dec_uop = '{unit: UNIT_BRU, op: OP_BNE, wr_rd: 1'b0, use_imm: 1'b1};
            dec_imm = offs16;
        end else if (inst[31:26] == OPC6_B) begin
            dec_uop = '{unit: UNIT_BRU, op: OP_B, wr_rd: 1'b0, use_imm: 1'b1};
            dec_imm = offs26;
        end else if (inst[31:26] == OPC6_BL) begin
            dec_uop = '{unit: UNIT_BRU, op: OP_BL, wr_rd: 1'b1, use_imm: 1'b1};
            dec_imm = offs26;
            dec_rd  = 5'd1; // link register r1
        end else if (inst[31:26] == OPC6_JIRL) begin
            dec_uop = '{unit: UNIT_BRU, op: OP_JIRL, wr_rd: 1'b1, use_imm: 1'b1};
            dec_imm = offs16;
        end else if (inst[31:15] == OPC17_SYSCALL) begin
            dec_exc = EXC_SYS; // no unit, trap only
        end else if (inst[31:15] == OPC17_BREAK) begin
            dec_exc = EXC_BRK;
        end else begin
            dec_exc = EXC_INE;
        end
    end

    assign uop     = entry_valid ? dec_uop : uop_t'('0);
    assign imm     = dec_imm;
    assign rd      = dec_rd;
    assign rj      = inst[9:5];
    assign rk      = inst[14:10];
    assign pc      = entry.pc;
    assign pc_next = entry.pc_next;
    assign valid   = entry_valid;

    // fetch fault wins over anything found while decoding
    assign exc = !entry_valid           ? EXC_NONE  :
                 (entry.exc != EXC_NONE) ? entry.exc :
                                           dec_exc;

endmodule

/* source/fetch_buffer.sv */
// ##########################################################
// two interleaved queues, FB_DEPTH must be a power of two
// one slot per bank stays unused, usable depth is FB_DEPTH-1
// ##########################################################
`timescale 1ns/1ps

module fetch_buffer
    import id_pkg::*;
#(
    parameter int FB_DEPTH = 8,
    parameter int FB_SLACK = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  fb_entry_t  push_entry0, // oldest new entry
    input  fb_entry_t  push_entry1,
    input  logic [1:0] push_count,  // 0..2
    input  logic [1:0] read_en,     // 00 none, 01 one, 11 two
    output fb_entry_t  head_entry0, // oldest queued entry
    output fb_entry_t  head_entry1,
    output logic       head_valid0,
    output logic       head_valid1,
    output logic       full
);

    localparam int PW = $clog2(FB_DEPTH);

    typedef logic [PW-1:0] ptr_t;

    fb_entry_t bank0 [FB_DEPTH];
    fb_entry_t bank1 [FB_DEPTH];

    ptr_t head0, head1;
    ptr_t tail0, tail1;
    ptr_t used0, used1;
    logic push_sel; // bank that takes push_entry0
    logic pop_sel;  // bank holding the oldest entry
    logic empty0, empty1;
    logic full0, full1, really_full;
    logic push0, push1, pop0, pop1;
    fb_entry_t wdata0, wdata1;
    fb_entry_t rdata0, rdata1;

    assign used0  = tail0 - head0; // wraps, depth is 2^PW
    assign used1  = tail1 - head1;
    assign empty0 = (head0 == tail0);
    assign empty1 = (head1 == tail1);
    assign full0  = (used0 == ptr_t'(FB_DEPTH - 1));
    assign full1  = (used1 == ptr_t'(FB_DEPTH - 1));
    assign really_full = full0 | full1;

    // early warning, fetch needs a few cycles to stop
    assign full = (used0 >= ptr_t'(FB_DEPTH - 1 - FB_SLACK))
               || (used1 >= ptr_t'(FB_DEPTH - 1 - FB_SLACK));

    // a pair fills both banks, a single goes to push_sel
    assign push0 = !really_full
                && ((push_count == 2'd2) || ((push_count == 2'd1) && !push_sel));
    assign push1 = !really_full
                && ((push_count == 2'd2) || ((push_count == 2'd1) && push_sel));

    assign wdata0 = push_sel ? push_entry1 : push_entry0;
    assign wdata1 = push_sel ? push_entry0 : push_entry1;

    // read_en 10 is not expected, treated like 11
    assign pop0 = !empty0 && (read_en[1] || (read_en[0] && !pop_sel));
    assign pop1 = !empty1 && (read_en[1] || (read_en[0] && pop_sel));

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head0    <= '0;
            head1    <= '0;
            tail0    <= '0;
            tail1    <= '0;
            push_sel <= 1'b0;
            pop_sel  <= 1'b0;
        end else begin
            if (push0) tail0 <= tail0 + 1'b1;
            if (push1) tail1 <= tail1 + 1'b1;
            if (pop0) head0 <= head0 + 1'b1;
            if (pop1) head1 <= head1 + 1'b1;
            // odd moves swap which bank is oldest
            if (push0 ^ push1) push_sel <= ~push_sel;
            if (pop0 ^ pop1) pop_sel <= ~pop_sel;
        end
    end

    // storage only, pointers decide what is live
    always_ff @(posedge clk) begin
        if (push0) bank0[tail0] <= wdata0;
        if (push1) bank1[tail1] <= wdata1;
    end

    // zero entry on an empty bank keeps x out of the decoders
    assign rdata0 = empty0 ? fb_entry_t'('0) : bank0[head0];
    assign rdata1 = empty1 ? fb_entry_t'('0) : bank1[head1];

    assign head_entry0 = pop_sel ? rdata1 : rdata0;
    assign head_entry1 = pop_sel ? rdata0 : rdata1;
    assign head_valid0 = pop_sel ? !empty1 : !empty0;
    // second only counts behind a valid first
    assign head_valid1 = head_valid0 && (pop_sel ? !empty0 : !empty1);

endmodule

/* source/pre_decoder.sv */
// ##########################################################
// branch class and byte offset of one instruction
// only beq, bne, b, bl and jirl count as branches here
// ##########################################################
`timescale 1ns/1ps

module pre_decoder
    import id_pkg::*;
(
    input  inst_t   inst,
    output br_cat_t category,
    output addr_t   offset
);

    addr_t offs16; // beq, bne, jirl
    addr_t offs26; // b, bl

    // offs16 sits in [25:10]
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    // offs26 is split, high part in [9:0]
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        category = CAT_NONE;
        offset   = '0; // non-branch
        case (inst[31:26])
            OPC6_BEQ, OPC6_BNE: begin
                category = CAT_COND;
                offset   = offs16;
            end
            OPC6_B, OPC6_BL: begin
                category = CAT_DIRECT;
                offset   = offs26;
            end
            OPC6_JIRL: begin
                // target also needs rj, predictor resolves it
                category = CAT_INDIRECT;
                offset   = offs16;
            end
            default: begin
                category = CAT_NONE;
                offset   = '0;
            end
        endcase
    end

endmodule

/* source/id_pkg.sv */
// ##########################################################
// shared types for the decode stage of the LA32 subset core
// opcode constants cover only the supported instructions
// ##########################################################
package id_pkg;

    typedef logic [31:0] addr_t;    // instruction address
    typedef logic [31:0] inst_t;    // raw instruction word
    typedef logic [4:0]  reg_idx_t; // architectural register number
    typedef logic [6:0]  exc_t;     // exception code, zero when clean

    // exception codes
    localparam exc_t EXC_NONE = 7'h00;
    localparam exc_t EXC_PIF  = 7'h03; // fetch page invalid
    localparam exc_t EXC_PPI  = 7'h07; // fetch privilege fault
    localparam exc_t EXC_ADEF = 7'h08; // fetch address error
    localparam exc_t EXC_SYS  = 7'h0b;
    localparam exc_t EXC_BRK  = 7'h0c;
    localparam exc_t EXC_INE  = 7'h0d; // illegal instruction
    localparam exc_t EXC_TLBR = 7'h3f; // fetch tlb refill

    // branch class seen by the predictor
    typedef enum logic [1:0] {
        CAT_NONE     = 2'b00,
        CAT_COND     = 2'b01, // beq, bne
        CAT_DIRECT   = 2'b10, // b, bl
        CAT_INDIRECT = 2'b11  // jirl
    } br_cat_t;

    typedef enum logic [1:0] {
        UNIT_NONE = 2'b00,
        UNIT_ALU  = 2'b01,
        UNIT_LSU  = 2'b10,
        UNIT_BRU  = 2'b11
    } uop_unit_t;

    // operation codes inside a unit
    localparam logic [3:0] OP_ADD  = 4'd0;
    localparam logic [3:0] OP_SUB  = 4'd1;
    localparam logic [3:0] OP_LUI  = 4'd2;
    localparam logic [3:0] OP_LD   = 4'd3;
    localparam logic [3:0] OP_ST   = 4'd4;
    localparam logic [3:0] OP_BEQ  = 4'd5;
    localparam logic [3:0] OP_BNE  = 4'd6;
    localparam logic [3:0] OP_B    = 4'd7;
    localparam logic [3:0] OP_BL   = 4'd8;
    localparam logic [3:0] OP_JIRL = 4'd9;

    typedef struct packed {
        uop_unit_t  unit;
        logic [3:0] op;
        logic       wr_rd;   // result goes to rd
        logic       use_imm; // second operand is imm
    } uop_t;

    // one queued instruction, 103 bits
    typedef struct packed {
        exc_t  exc;
        addr_t pc_next;
        addr_t pc;
        inst_t inst;
    } fb_entry_t;

    // opcode fields, matched at different widths of inst[31:x]
    localparam logic [16:0] OPC17_ADD_W   = 17'h00020; // inst[31:15]
    localparam logic [16:0] OPC17_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC17_BREAK   = 17'h00054;
    localparam logic [16:0] OPC17_SYSCALL = 17'h00056;
    localparam logic [9:0]  OPC10_ADDI_W  = 10'h00a;   // inst[31:22]
    localparam logic [9:0]  OPC10_LD_W    = 10'h0a2;
    localparam logic [9:0]  OPC10_ST_W    = 10'h0a6;
    localparam logic [6:0]  OPC7_LU12I_W  = 7'h0a;     // inst[31:25]
    localparam logic [5:0]  OPC6_JIRL     = 6'h13;     // inst[31:26]
    localparam logic [5:0]  OPC6_B        = 6'h14;
    localparam logic [5:0]  OPC6_BL       = 6'h15;
    localparam logic [5:0]  OPC6_BEQ      = 6'h16;
    localparam logic [5:0]  OPC6_BNE      = 6'h17;

    localparam inst_t INST_NOP = 32'h0340_0000; // andi r0,r0,0

endpackage
